/* rtl/rvIsaPkg.sv */
package rvIsaPkg;

    localparam int xlen    = 32;
    localparam int regBits = 5;

    typedef logic [xlen-1:0]    instWord;
    typedef logic [xlen-1:0]    xlenWord;
    typedef logic [regBits-1:0] regName;
    typedef logic [2:0]         funct3Field;

    // RV32I major opcodes, inst[6:0].
    typedef enum logic [6:0] {
        opcLui    = 7'b0110111,
        opcAuipc  = 7'b0010111,
        opcJal    = 7'b1101111,
        opcJalr   = 7'b1100111,
        opcBranch = 7'b1100011,
        opcLoad   = 7'b0000011,
        opcStore  = 7'b0100011,
        opcOpImm  = 7'b0010011,
        opcOp     = 7'b0110011
    } majorOpcode;

    // Internal ops. Encoding order is fixed, NOP is zero.
    typedef enum logic [5:0] {
        uopNop,
        uopLui, uopAuipc, uopJal, uopJalr,
        // Branches from 5.
        uopBeq, uopBne, uopBlt, uopBge, uopBltu, uopBgeu,
        // Loads from 11, stores from 16.
        uopLb, uopLh, uopLw, uopLbu, uopLhu,
        uopSb, uopSh, uopSw,
        // Immediate ALU ops from 19.
        uopAddi, uopSlti, uopSltiu, uopXori, uopOri, uopAndi,
        uopSlli, uopSrli, uopSrai,
        // Register ALU ops from 28.
        uopAdd, uopSub, uopSll, uopSlt, uopSltu,
        uopXor, uopSrl, uopSra, uopOr, uopAnd
    } uopOp;

endpackage

/* rtl/coreUopPkg.sv */
package coreUopPkg;

    // Reorder buffer tag, 16 entries at most.
    typedef logic [3:0] robTag;

    typedef struct packed {
        rvIsaPkg::instWord inst;
        rvIsaPkg::xlenWord pc;
        logic              predJump;
    } fetchEntry;

    typedef struct packed {
        rvIsaPkg::uopOp    op;
        rvIsaPkg::xlenWord imm;
        rvIsaPkg::xlenWord pc;
        logic              predJump;
        rvIsaPkg::regName  rs1;
        rvIsaPkg::regName  rs2;
        rvIsaPkg::regName  rd;
        logic              usesRs1;
        logic              usesRs2;
        logic              writesRd;
    } decodedUop;

    // Tag is only meaningful while ready is low.
    typedef struct packed {
        logic              ready;
        rvIsaPkg::xlenWord value;
        robTag             tag;
    } srcOperand;

    typedef struct packed {
        rvIsaPkg::uopOp    op;
        rvIsaPkg::xlenWord imm;
        rvIsaPkg::xlenWord pc;
        logic              predJump;
        srcOperand         src1;
        srcOperand         src2;
        rvIsaPkg::regName  rd;
        robTag             destTag;
    } issuePacket;

    typedef struct packed {
        robTag             tag;
        rvIsaPkg::regName  rd;
        logic              hasRd;
        rvIsaPkg::xlenWord data;
    } writebackBus;

endpackage

/* rtl/instQueue.sv */
`timescale 1ns/1ns

module instQueue #(
    parameter int queueDepth = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,
    input  coreUopPkg::fetchEntry pushData,
    input  logic                  pop,
    output coreUopPkg::fetchEntry head,
    output logic                  empty,
    output logic                  full
);
    import coreUopPkg::*;

    localparam int ptrWidth   = $clog2(queueDepth);
    localparam int countWidth = $clog2(queueDepth + 1);

    fetchEntry             mem [queueDepth];
    logic [ptrWidth-1:0]   rdPtr;
    logic [ptrWidth-1:0]   wrPtr;
    logic [countWidth-1:0] count;
    logic                  doPush;
    logic                  doPop;

    assign doPush = push && !full;
    assign doPop  = pop && !empty;

    assign head  = mem[rdPtr];
    assign empty = (count == '0);
    assign full  = (count == countWidth'(queueDepth));

    // Pointers wrap on their own for a power-of-two depth.
    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

endmodule

/* rtl/instDecoder.sv */
`timescale 1ns/1ns

module instDecoder (
    input  coreUopPkg::fetchEntry entry,
    output coreUopPkg::decodedUop uop
);
    import rvIsaPkg::*;

    instWord    inst;
    majorOpcode opcode;
    funct3Field funct3;
    logic       bit30;
    xlenWord    immI;
    xlenWord    immS;
    xlenWord    immB;
    xlenWord    immU;
    xlenWord    immJ;

    assign inst   = entry.inst;
    assign opcode = majorOpcode'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign bit30  = inst[30];

    ////////////////////////////////////////////////////////////////////////////
    // Immediate formats, all sign extended.
    ////////////////////////////////////////////////////////////////////////////

    assign immI = {{21{inst[31]}}, inst[30:20]};
    assign immS = {{21{inst[31]}}, inst[30:25], inst[11:7]};
    assign immB = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {inst[31:12], 12'b0};
    assign immJ = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        uop          = '0;
        uop.pc       = entry.pc;
        uop.predJump = entry.predJump;
        uop.rs1      = inst[19:15];
        uop.rs2      = inst[24:20];
        uop.rd       = inst[11:7];
        uop.op       = uopNop;
        case (opcode)
            opcLui, opcAuipc: begin
                uop.op       = (opcode == opcLui) ? uopLui : uopAuipc;
                uop.imm      = immU;
                uop.writesRd = 1'b1;
            end
            opcJal: begin
                uop.op       = uopJal;
                uop.imm      = immJ;
                uop.writesRd = 1'b1;
            end
            opcJalr: begin
                if (funct3 == 3'b000) begin
                    uop.op = uopJalr;
                end
                uop.imm      = immI;
                uop.usesRs1  = 1'b1;
                uop.writesRd = 1'b1;
            end
            opcBranch: begin
                uop.imm     = immB;
                uop.usesRs1 = 1'b1;
                uop.usesRs2 = 1'b1;
                case (funct3)
                    3'b000:  uop.op = uopBeq;
                    3'b001:  uop.op = uopBne;
                    3'b100:  uop.op = uopBlt;
                    3'b101:  uop.op = uopBge;
                    3'b110:  uop.op = uopBltu;
                    3'b111:  uop.op = uopBgeu;
                    default: uop.op = uopNop;
                endcase
            end
            opcLoad: begin
                uop.imm      = immI;
                uop.usesRs1  = 1'b1;
                uop.writesRd = 1'b1;
                case (funct3)
                    3'b000:  uop.op = uopLb;
                    3'b001:  uop.op = uopLh;
                    3'b010:  uop.op = uopLw;
                    3'b100:  uop.op = uopLbu;
                    3'b101:  uop.op = uopLhu;
                    default: uop.op = uopNop;
                endcase
            end
            opcStore: begin
                uop.imm     = immS;
                uop.usesRs1 = 1'b1;
                uop.usesRs2 = 1'b1;
                case (funct3)
                    3'b000:  uop.op = uopSb;
                    3'b001:  uop.op = uopSh;
                    3'b010:  uop.op = uopSw;
                    default: uop.op = uopNop;
                endcase
            end
            opcOpImm: begin
                uop.imm      = immI;
                uop.usesRs1  = 1'b1;
                uop.writesRd = 1'b1;
                // Bit 30 only matters for the shifts.
                case ({bit30, funct3})
                    4'b0000, 4'b1000: uop.op = uopAddi;
                    4'b0010, 4'b1010: uop.op = uopSlti;
                    4'b0011, 4'b1011: uop.op = uopSltiu;
                    4'b0100, 4'b1100: uop.op = uopXori;
                    4'b0110, 4'b1110: uop.op = uopOri;
                    4'b0111, 4'b1111: uop.op = uopAndi;
                    4'b0001:          uop.op = uopSlli;
                    4'b0101:          uop.op = uopSrli;
                    4'b1101:          uop.op = uopSrai;
                    default:          uop.op = uopNop;
                endcase
            end
            opcOp: begin
                uop.usesRs1  = 1'b1;
                uop.usesRs2  = 1'b1;
                uop.writesRd = 1'b1;
                case ({bit30, funct3})
                    4'b0000: uop.op = uopAdd;
                    4'b1000: uop.op = uopSub;
                    4'b0001: uop.op = uopSll;
                    4'b0010: uop.op = uopSlt;
                    4'b0011: uop.op = uopSltu;
                    4'b0100: uop.op = uopXor;
                    4'b0101: uop.op = uopSrl;
                    4'b1101: uop.op = uopSra;
                    4'b0110: uop.op = uopOr;
                    4'b0111: uop.op = uopAnd;
                    default: uop.op = uopNop;
                endcase
            end
            default: begin
                uop.op = uopNop;
            end
        endcase
        // Illegal encodings carry no operands, immediate or result.
        if (uop.op == uopNop) begin
            uop.imm      = '0;
            uop.usesRs1  = 1'b0;
            uop.usesRs2  = 1'b0;
            uop.writesRd = 1'b0;
        end
        // x0 is never renamed.
        if (uop.rd == '0) begin
            uop.writesRd = 1'b0;
        end
    end

endmodule

/* rtl/regStatusFile.sv */
`timescale 1ns/1ns

module regStatusFile (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    dispatch,
    input  coreUopPkg::decodedUop   uop,
    input  coreUopPkg::robTag       destTag,
    input  logic                    wbValid,
    input  coreUopPkg::writebackBus wb,
    output logic                    issueValid,
    output coreUopPkg::issuePacket  issue
);
    import rvIsaPkg::*;
    import coreUopPkg::*;

    xlenWord     regValue [32];
    robTag       regOwner [32];
    logic [31:0] regBusy;
    logic        wbHit;
    srcOperand   src1;
    srcOperand   src2;

    // Writeback from the current owner of its register.
    assign wbHit = wbValid && wb.hasRd && (wb.rd != '0) && regBusy[wb.rd]
                   && (regOwner[wb.rd] == wb.tag);

    function automatic srcOperand readSource(input logic used, input regName rs);
        srcOperand src;
        src       = '0;
        src.ready = 1'b1;
        if (used && (rs != '0)) begin
            if (!regBusy[rs]) begin
                src.value = regValue[rs];
            end else if (wbHit && (wb.rd == rs)) begin
                // Bypass.
                src.value = wb.data;
            end else begin
                src.ready = 1'b0;
                src.tag   = regOwner[rs];
            end
        end
        return src;
    endfunction

    always_comb begin
        src1 = readSource(uop.usesRs1, uop.rs1);
        src2 = readSource(uop.usesRs2, uop.rs2);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Register values and busy table.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            regBusy <= '0;
            for (int i = 0; i < 32; i++) begin
                regValue[i] <= '0;
            end
        end else begin
            if (wbHit) begin
                regValue[wb.rd] <= wb.data;
                regBusy[wb.rd]  <= 1'b0;
            end
            // A new writer overrides a same-cycle writeback.
            if (dispatch && uop.writesRd) begin
                regBusy[uop.rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch && uop.writesRd) begin
            regOwner[uop.rd] <= destTag;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Issue register.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            issueValid <= 1'b0;
        end else begin
            issueValid <= dispatch;
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch) begin
            issue.op       <= uop.op;
            issue.imm      <= uop.imm;
            issue.pc       <= uop.pc;
            issue.predJump <= uop.predJump;
            issue.src1     <= src1;
            issue.src2     <= src2;
            issue.rd       <= uop.rd;
            issue.destTag  <= destTag;
        end
    end

endmodule

/* rtl/robTagAllocator.sv */
`timescale 1ns/1ns

module robTagAllocator #(
    parameter int robDepth = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              alloc,
    input  logic              commit,
    output coreUopPkg::robTag nextTag,
    output logic              robFull
);
    import coreUopPkg::*;

    localparam int countWidth = $clog2(robDepth + 1);

    robTag                 allocPtr;
    logic [countWidth-1:0] occupancy;
    logic                  doAlloc;
    logic                  doCommit;

    assign doAlloc  = alloc && !robFull;
    assign doCommit = commit && (occupancy != '0);

    assign nextTag = allocPtr;
    assign robFull = (occupancy == countWidth'(robDepth));

    always_ff @(posedge clk) begin
        if (rst) begin
            allocPtr  <= '0;
            occupancy <= '0;
        end else begin
            if (doAlloc) begin
                if (allocPtr == robTag'(robDepth - 1)) begin
                    allocPtr <= '0;
                end else begin
                    allocPtr <= allocPtr + 1'b1;
                end
            end
            if (doAlloc && !doCommit) begin
                occupancy <= occupancy + 1'b1;
            end else if (doCommit && !doAlloc) begin
                occupancy <= occupancy - 1'b1;
            end
        end
    end

endmodule

/* rtl/frontEnd.sv */
`timescale 1ns/1ns

module frontEnd #(
    parameter int queueDepth = 4,
    parameter int robDepth   = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rdy,
    input  logic                    fetchValid,
    input  coreUopPkg::fetchEntry   fetchIn,
    input  logic                    wbValid,
    input  coreUopPkg::writebackBus wb,
    input  logic                    commitValid,
    output logic                    queueFull,
    output logic                    issueValid,
    output coreUopPkg::issuePacket  issue
);
    import coreUopPkg::*;

    fetchEntry head;
    decodedUop uop;
    robTag     nextTag;
    logic      queueEmpty;
    logic      robFull;
    logic      dispatch;

    // One instruction per cycle when the core can take it.
    assign dispatch = rdy && !queueEmpty && !robFull;

    instQueue #(
        .queueDepth(queueDepth)
    ) queue (
        .clk     (clk),
        .rst     (rst),
        .push    (fetchValid),
        .pushData(fetchIn),
        .pop     (dispatch),
        .head    (head),
        .empty   (queueEmpty),
        .full    (queueFull)
    );

    instDecoder decoder (
        .entry(head),
        .uop  (uop)
    );

    regStatusFile operands (
        .clk       (clk),
        .rst       (rst),
        .dispatch  (dispatch),
        .uop       (uop),
        .destTag   (nextTag),
        .wbValid   (wbValid),
        .wb        (wb),
        .issueValid(issueValid),
        .issue     (issue)
    );

    robTagAllocator #(
        .robDepth(robDepth)
    ) tags (
        .clk    (clk),
        .rst    (rst),
        .alloc  (dispatch),
        .commit (commitValid),
        .nextTag(nextTag),
        .robFull(robFull)
    );

endmodule

/* verif/frontEndTb.sv */
`timescale 1ns/1ns

module frontEndTb;
    import rvIsaPkg::*;
    import coreUopPkg::*;

    localparam int queueDepth = 4;
    localparam int robDepth   = 8;
    localparam int numRecords = 21;
    localparam int recWords   = 9;

    logic        clk;
    logic        rst;
    logic        rdy;
    logic        fetchValid;
    fetchEntry   fetchIn;
    logic        wbValid;
    writebackBus wb;
    logic        commitValid;
    logic        queueFull;
    logic        issueValid;
    issuePacket  issue;

    logic [31:0] golden [numRecords*recWords];
    logic [15:0] lfsrState;
    int          errors [3];

    // Reference model of the operand stage and tag bookkeeping.
    xlenWord     modelValue [32];
    robTag       modelOwner [32];
    logic [31:0] modelBusy;
    int          modelQ [$];
    int          modelOcc;
    robTag       flightTag [$];
    regName      flightRd [$];
    logic        flightHasRd [$];
    int          flightDue [$];
    logic        flightDone [$];

    logic        expValid;
    int          expRec;
    srcOperand   expSrc1;
    srcOperand   expSrc2;
    robTag       expTag;
    int          fetchRec;
    int          nextRec;
    int          dispatchCount;
    int          issuedCount;
    int          issuePulses;
    int          cycle;
    logic        postReset;

    frontEnd #(
        .queueDepth(queueDepth),
        .robDepth  (robDepth)
    ) dut (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .fetchValid (fetchValid),
        .fetchIn    (fetchIn),
        .wbValid    (wbValid),
        .wb         (wb),
        .commitValid(commitValid),
        .queueFull  (queueFull),
        .issueValid (issueValid),
        .issue      (issue)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Taps 16, 14, 13, 11.
    function automatic logic randomBit();
        logic fb;
        fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
        lfsrState = {lfsrState[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] field(input int rec, input int k);
        return golden[rec*recWords + k];
    endfunction

    function automatic logic bitOf(input int rec, input int k, input int b);
        logic [31:0] w;
        w = field(rec, k);
        return w[b];
    endfunction

    function automatic regName regOf(input int rec, input int k);
        return regName'(field(rec, k));
    endfunction

    task automatic checkField(input string name, input logic [31:0] got,
                              input logic [31:0] exp, input int kind);
        assert (got === exp) else begin
            $display("Fail time %0t %s expected %h got %h", $time, name, exp, got);
            errors[kind]++;
        end
    endtask

    function automatic srcOperand expectedSource(input logic used, input regName rs);
        srcOperand src;
        src       = '0;
        src.ready = 1'b1;
        if (used && (rs != '0)) begin
            if (!modelBusy[rs]) begin
                src.value = modelValue[rs];
            end else if (wbValid && wb.hasRd && (wb.rd == rs) && (modelOwner[rs] == wb.tag)) begin
                src.value = wb.data;
            end else begin
                src.ready = 1'b0;
                src.tag   = modelOwner[rs];
            end
        end
        return src;
    endfunction

    task automatic checkSource(input string name, input srcOperand got, input srcOperand exp);
        checkField({name, ".ready"}, 32'(got.ready), 32'(exp.ready), 1);
        if (exp.ready) begin
            checkField({name, ".value"}, got.value, exp.value, 1);
        end else begin
            checkField({name, ".tag"}, 32'(got.tag), 32'(exp.tag), 1);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Per-edge checks, model update and stimulus.
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        logic dispatch;
        logic fullBefore;
        int   r;
        if (rst) begin
            // Outputs settle after the first reset edge.
            if (postReset) begin
                checkField("issueValid", 32'(issueValid), 32'd0, 2);
                checkField("queueFull", 32'(queueFull), 32'd0, 2);
            end
            postReset = 1'b1;
        end else begin
            cycle++;
            if (postReset) begin
                checkField("queueFull", 32'(queueFull), 32'd0, 2);
                postReset = 1'b0;
            end
            fullBefore = (modelQ.size() == queueDepth);
            checkField("queueFull", 32'(queueFull), 32'(fullBefore), 2);
            checkField("issueValid", 32'(issueValid), 32'(expValid), 2);
            if (issueValid) begin
                issuePulses++;
            end
            if (issueValid && expValid) begin
                issuedCount++;
                checkField("issue.op", 32'(issue.op), field(expRec, 3), 0);
                checkField("issue.imm", issue.imm, field(expRec, 4), 0);
                checkField("issue.pc", issue.pc, field(expRec, 1), 0);
                checkField("issue.predJump", 32'(issue.predJump), field(expRec, 2), 0);
                checkField("issue.destTag", 32'(issue.destTag), 32'(expTag), 2);
                if (bitOf(expRec, 8, 0)) begin
                    checkField("issue.rd", 32'(issue.rd), field(expRec, 7), 0);
                end
                checkSource("issue.src1", issue.src1, expSrc1);
                checkSource("issue.src2", issue.src2, expSrc2);
            end

            dispatch = rdy && (modelQ.size() > 0) && (modelOcc < robDepth);
            expValid = dispatch;
            if (dispatch) begin
                r       = modelQ.pop_front();
                expRec  = r;
                expSrc1 = expectedSource(bitOf(r, 8, 2), regOf(r, 5));
                expSrc2 = expectedSource(bitOf(r, 8, 1), regOf(r, 6));
                expTag  = robTag'(dispatchCount % robDepth);
                flightTag.push_back(expTag);
                flightRd.push_back(regOf(r, 7));
                flightHasRd.push_back(bitOf(r, 8, 0));
                flightDue.push_back(cycle + 1 + int'({randomBit(), randomBit(), randomBit()}));
                flightDone.push_back(1'b0);
                dispatchCount++;
            end
            if (wbValid && wb.hasRd && (wb.rd != '0) && modelBusy[wb.rd]
                && (modelOwner[wb.rd] == wb.tag)) begin
                modelValue[wb.rd] = wb.data;
                modelBusy[wb.rd]  = 1'b0;
            end
            if (dispatch && bitOf(r, 8, 0)) begin
                modelBusy[regOf(r, 7)]  = 1'b1;
                modelOwner[regOf(r, 7)] = expTag;
            end
            modelOcc = modelOcc + int'(dispatch) - int'(commitValid && (modelOcc > 0));
            if (fetchValid && !fullBefore) begin
                modelQ.push_back(fetchRec);
            end

            rdy         <= randomBit() | randomBit();
            commitValid <= 1'b0;
            if ((flightDone.size() > 0) && flightDone[0]) begin
                commitValid <= 1'b1;
                void'(flightTag.pop_front());
                void'(flightRd.pop_front());
                void'(flightHasRd.pop_front());
                void'(flightDue.pop_front());
                void'(flightDone.pop_front());
            end
            wbValid <= 1'b0;
            for (int i = 0; i < flightDone.size(); i++) begin
                if (!flightDone[i] && (flightDue[i] <= cycle)) begin
                    wbValid       <= 1'b1;
                    wb.tag        <= flightTag[i];
                    wb.rd         <= flightRd[i];
                    wb.hasRd      <= flightHasRd[i];
                    wb.data       <= 32'(flightTag[i]) * 32'h101;
                    flightDone[i] = 1'b1;
                    break;
                end
            end
            // Only drive a fetch that the queue is sure to accept.
            fetchValid <= 1'b0;
            if ((nextRec < numRecords) && (modelQ.size() < queueDepth)) begin
                fetchValid       <= 1'b1;
                fetchIn.inst     <= field(nextRec, 0);
                fetchIn.pc       <= field(nextRec, 1);
                fetchIn.predJump <= bitOf(nextRec, 2, 0);
                fetchRec = nextRec;
                nextRec++;
            end
        end
    end

    initial begin
        rst           <= 1'b1;
        rdy           <= 1'b0;
        fetchValid    <= 1'b0;
        fetchIn       <= '0;
        wbValid       <= 1'b0;
        wb            <= '0;
        commitValid   <= 1'b0;
        lfsrState     = 16'd48580;
        modelBusy     = '0;
        modelOcc      = 0;
        expValid      = 1'b0;
        nextRec       = 0;
        fetchRec      = 0;
        dispatchCount = 0;
        issuedCount   = 0;
        issuePulses   = 0;
        cycle         = 0;
        postReset     = 1'b0;
        for (int i = 0; i < 3; i++) begin
            errors[i] = 0;
        end
        for (int i = 0; i < 32; i++) begin
            modelValue[i] = '0;
            modelOwner[i] = '0;
        end
        $readmemh("verif/frontEndGolden.txt", golden);
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        while (issuedCount < numRecords) begin
            @(posedge clk);
        end
        repeat (5) @(negedge clk);
        checkField("issuePulses", 32'(issuePulses), 32'(numRecords), 2);
        $display("Errors decode %0d operand %0d flow %0d", errors[0], errors[1], errors[2]);
        if (errors[0] + errors[1] + errors[2] == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        repeat (numRecords*40 + 200) @(posedge clk);
        $display("Timeout with %0d of %0d packets issued", issuedCount, numRecords);
        $display("Checks failed");
        $finish;
    end

endmodule

/* verif/frontEndGolden.txt */
// inst pc predJump op imm rs1 rs2 rd flags
// flags: bit2 usesRs1, bit1 usesRs2, bit0 writesRd; rs1 and rs2 are zero when unused
123450B7 00001000 0 01 12345000 00 00 01 1
FFB08113 00001004 0 13 FFFFFFFB 01 00 02 5
002081B3 00001008 0 1C 00000000 01 02 03 7
40118233 0000100C 0 1D 00000000 03 01 04 7
00321293 00001010 0 19 00000003 04 00 05 5
4022D313 00001014 0 1B 00000402 05 00 06 5
00612423 00001018 0 12 00000008 02 06 00 6
FFC32383 0000101C 0 0D FFFFFFFC 06 00 07 5
FE338CE3 00001020 1 05 FFFFFFF8 07 03 00 6
010000EF 00001024 1 03 00000010 00 00 01 1
00008067 00001028 0 04 00000000 01 00 00 4
FFFFF417 0000102C 0 02 FFFFF000 00 00 08 1
FFFFFFFF 00001030 0 00 00000000 00 00 00 0
40209233 00001034 0 00 00000000 00 00 00 0
00002063 00001038 1 00 00000000 00 00 00 0
FFF44493 0000103C 0 16 FFFFFFFF 08 00 09 5
0014D513 00001040 0 1A 00000001 09 00 0A 5
00051663 00001044 1 06 0000000C 0A 00 00 6
005575B3 00001048 0 25 00000000 0A 05 0B 7
4025D133 0000104C 0 23 00000000 0B 02 02 7
FE200FA3 00001050 0 10 FFFFFFFF 00 02 00 6

/* filelist.f */
rtl/rvIsaPkg.sv
rtl/coreUopPkg.sv
rtl/instQueue.sv
rtl/instDecoder.sv
rtl/regStatusFile.sv
rtl/robTagAllocator.sv
rtl/frontEnd.sv
verif/frontEndTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= frontEndTb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf $(OBJ_DIR)
